// File: logic/bus_pkg.sv
package bus_pkg;

    // ########################################
    // bus geometry
    // ########################################
    parameter int BUS_W  = 73;
    parameter int ADDR_W = 15;
    parameter int WORD_W = 32;
    parameter int LOC_W  = 4;
    parameter int SIZE_W = 16;
    parameter int MASK_W = 4;
    parameter int SLOT_W = 2;
    parameter int LINE_W = MASK_W * WORD_W;

    // field positions within one 73-bit beat.
    parameter int VALID_BIT = 0;
    parameter int ADDR_LSB  = 1;
    parameter int DATA_LSB  = 16;
    parameter int RET_LSB   = 48;
    parameter int DEST_LSB  = 52;
    parameter int RW_BIT    = 56;
    parameter int SIZE_LSB  = 57;

    typedef enum logic [2:0] {S_IDLE, S_WAIT_GRANT, S_HEADER, S_DATA, S_ACK_HOLD} sender_state_e;
    typedef enum logic [1:0] {RX_FREE, RX_ARMED, RX_CAPTURE, RX_FULL} rx_state_e;
    typedef enum logic {ARB_IDLE, ARB_BUSY} arb_state_e;

    // index of the lowest set bit, which is the next word slot to move.
    function automatic logic [SLOT_W-1:0] low_slot(input logic [MASK_W-1:0] m);
        logic [SLOT_W-1:0] idx;
        idx = '0;
        for (int i = MASK_W - 1; i >= 0; i--) begin
            if (m[i]) begin
                idx = SLOT_W'(i);
            end
        end
        return idx;
    endfunction

    // the mask that is left once the lowest slot has been moved.
    function automatic logic [MASK_W-1:0] clear_low(input logic [MASK_W-1:0] m);
        return m & (m - MASK_W'(1));
    endfunction

endpackage

// File: logic/bus_sender.sv
`timescale 1ns/1ps

module bus_sender (
    input  logic                        clk_bus,
    input  logic                        arst_n,
    input  logic                        req,
    input  logic [bus_pkg::ADDR_W-1:0]  addr,
    input  logic [bus_pkg::LINE_W-1:0]  data,
    input  logic [bus_pkg::MASK_W-1:0]  mask,
    input  logic [bus_pkg::LOC_W-1:0]   dest,
    input  logic [bus_pkg::LOC_W-1:0]   return_id,
    input  logic                        rw,
    input  logic                        grant,
    output logic                        ack,
    output logic                        bus_req,
    output logic [bus_pkg::LOC_W-1:0]   bus_dest,
    output logic [bus_pkg::BUS_W-1:0]   bus_word,
    output logic                        done
);

    bus_pkg::sender_state_e state;

    logic [bus_pkg::MASK_W-1:0] mask_left;
    logic [bus_pkg::MASK_W-1:0] mask_q;
    logic [bus_pkg::ADDR_W-1:0] addr_q;
    logic [bus_pkg::LINE_W-1:0] data_q;
    logic [bus_pkg::LOC_W-1:0]  ret_q;
    logic                       rw_q;
    logic                       last_data;

    assign last_data = (bus_pkg::clear_low(mask_left) == '0);
    assign bus_req   = (state == bus_pkg::S_WAIT_GRANT);
    assign ack       = (state == bus_pkg::S_ACK_HOLD);
    assign done      = ((state == bus_pkg::S_HEADER) && (mask_left == '0)) ||
                       ((state == bus_pkg::S_DATA) && last_data);

    // ########################################
    // handshake and beat sequencing
    // ########################################
    always_ff @(posedge clk_bus or negedge arst_n) begin
        if (!arst_n) begin
            state     <= bus_pkg::S_IDLE;
            mask_left <= '0;
            bus_dest  <= '0;
        end else begin
            case (state)
                bus_pkg::S_IDLE: begin
                    if (req) begin
                        mask_left <= mask;
                        bus_dest  <= dest;
                        state     <= bus_pkg::S_WAIT_GRANT;
                    end
                end
                bus_pkg::S_WAIT_GRANT: begin
                    if (grant) begin
                        state <= bus_pkg::S_HEADER;
                    end
                end
                bus_pkg::S_HEADER: begin
                    // a header-only transfer finishes here.
                    state <= (mask_left == '0) ? bus_pkg::S_ACK_HOLD : bus_pkg::S_DATA;
                end
                bus_pkg::S_DATA: begin
                    mask_left <= bus_pkg::clear_low(mask_left);
                    if (last_data) begin
                        state <= bus_pkg::S_ACK_HOLD;
                    end
                end
                default: begin
                    if (!req) begin
                        state <= bus_pkg::S_IDLE;
                    end
                end
            endcase
        end
    end

    // the transfer itself, captured when the core request is taken.
    always_ff @(posedge clk_bus) begin
        if ((state == bus_pkg::S_IDLE) && req) begin
            addr_q <= addr;
            data_q <= data;
            mask_q <= mask;
            ret_q  <= return_id;
            rw_q   <= rw;
        end
    end

    always_comb begin
        bus_word = '0;
        if (state == bus_pkg::S_HEADER) begin
            bus_word[bus_pkg::VALID_BIT]                     = 1'b1;
            bus_word[bus_pkg::ADDR_LSB +: bus_pkg::ADDR_W]   = addr_q;
            bus_word[bus_pkg::RET_LSB +: bus_pkg::LOC_W]     = ret_q;
            bus_word[bus_pkg::DEST_LSB +: bus_pkg::LOC_W]    = bus_dest;
            bus_word[bus_pkg::RW_BIT]                        = rw_q;
            bus_word[bus_pkg::SIZE_LSB +: bus_pkg::MASK_W]   = mask_q;
        end else if (state == bus_pkg::S_DATA) begin
            bus_word[bus_pkg::VALID_BIT]                     = 1'b1;
            bus_word[bus_pkg::DATA_LSB +: bus_pkg::WORD_W]   =
                data_q[bus_pkg::low_slot(mask_left) * bus_pkg::WORD_W +: bus_pkg::WORD_W];
            bus_word[bus_pkg::DEST_LSB +: bus_pkg::LOC_W]    = bus_dest;
        end
    end

    // the arbiter only grants senders that are asking for the bus.
    a_grant_needs_req: assert property (
        @(posedge clk_bus) disable iff (!arst_n) grant |-> bus_req
    );

endmodule

// File: logic/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter #(
    parameter int NUM_TX = 2,
    parameter int NUM_RX = 2
) (
    input  logic                                  clk_bus,
    input  logic                                  arst_n,
    input  logic [NUM_TX-1:0]                     bus_req,
    input  logic [NUM_TX-1:0][bus_pkg::LOC_W-1:0] bus_dest,
    input  logic [NUM_TX-1:0][bus_pkg::BUS_W-1:0] bus_word,
    input  logic [NUM_TX-1:0]                     done,
    input  logic [NUM_RX-1:0]                     free_bau,
    output logic [NUM_TX-1:0]                     grant,
    output logic [NUM_RX-1:0]                     set_receiver,
    output logic [bus_pkg::BUS_W-1:0]             bus
);

    localparam int TX_W = (NUM_TX > 1) ? $clog2(NUM_TX) : 1;

    bus_pkg::arb_state_e state;

    logic [TX_W-1:0] rr_ptr;
    logic [TX_W-1:0] owner;
    logic [TX_W-1:0] pick;
    logic            pick_ok;

    // ########################################
    // round-robin choice
    // ########################################
    // the search starts at rr_ptr and skips senders whose receiver is busy.
    always_comb begin
        int   j;
        logic dest_free;
        pick    = '0;
        pick_ok = 1'b0;
        for (int i = 0; i < NUM_TX; i++) begin
            j = int'(rr_ptr) + i;
            if (j >= NUM_TX) begin
                j = j - NUM_TX;
            end
            dest_free = 1'b0;
            for (int r = 0; r < NUM_RX; r++) begin
                if ((int'(bus_dest[j]) == r) && free_bau[r]) begin
                    dest_free = 1'b1;
                end
            end
            if (!pick_ok && bus_req[j] && dest_free) begin
                pick    = TX_W'(j);
                pick_ok = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_bus or negedge arst_n) begin
        if (!arst_n) begin
            state        <= bus_pkg::ARB_IDLE;
            rr_ptr       <= '0;
            owner        <= '0;
            grant        <= '0;
            set_receiver <= '0;
        end else begin
            grant        <= '0;
            set_receiver <= '0;
            if (state == bus_pkg::ARB_IDLE) begin
                if (pick_ok) begin
                    grant[pick] <= 1'b1;
                    for (int r = 0; r < NUM_RX; r++) begin
                        set_receiver[r] <= (int'(bus_dest[pick]) == r);
                    end
                    owner  <= pick;
                    rr_ptr <= (int'(pick) == NUM_TX - 1) ? '0 : pick + TX_W'(1);
                    state  <= bus_pkg::ARB_BUSY;
                end
            end else if (done[owner]) begin
                state <= bus_pkg::ARB_IDLE;
            end
        end
    end

    // the bus is quiet whenever nobody owns it.
    assign bus = (state == bus_pkg::ARB_BUSY) ? bus_word[owner] : '0;

    a_grant_onehot: assert property (
        @(posedge clk_bus) disable iff (!arst_n) $onehot0(grant)
    );

    // a grant is only ever the result of a decision taken while idle.
    a_grant_from_idle: assert property (
        @(posedge clk_bus) disable iff (!arst_n) (|grant) |-> $past(state) == bus_pkg::ARB_IDLE
    );

endmodule

// File: logic/bus_receiver.sv
`timescale 1ns/1ps

module bus_receiver #(
    parameter int LOC = 0
) (
    input  logic                        clk_bus,
    input  logic                        arst_n,
    input  logic [bus_pkg::BUS_W-1:0]   bus,
    input  logic                        set_receiver,
    input  logic                        read,
    output logic                        full,
    output logic                        free_bau,
    output logic [bus_pkg::ADDR_W-1:0]  addr,
    output logic [bus_pkg::LINE_W-1:0]  data,
    output logic [bus_pkg::LOC_W-1:0]   return_id,
    output logic [bus_pkg::LOC_W-1:0]   dest,
    output logic                        rw,
    output logic [bus_pkg::SIZE_W-1:0]  size
);

    bus_pkg::rx_state_e state;

    logic [bus_pkg::MASK_W-1:0] mask_left;
    logic                       bus_valid;
    logic [bus_pkg::LOC_W-1:0]  bus_dest;
    logic [bus_pkg::MASK_W-1:0] bus_mask;
    logic [bus_pkg::SLOT_W-1:0] slot;

    assign bus_valid = bus[bus_pkg::VALID_BIT];
    assign bus_dest  = bus[bus_pkg::DEST_LSB +: bus_pkg::LOC_W];
    assign bus_mask  = bus[bus_pkg::SIZE_LSB +: bus_pkg::MASK_W];
    assign slot      = bus_pkg::low_slot(mask_left);

    assign free_bau = (state == bus_pkg::RX_FREE);
    assign full     = (state == bus_pkg::RX_FULL);

    // ########################################
    // capture FSM
    // ########################################
    always_ff @(posedge clk_bus or negedge arst_n) begin
        if (!arst_n) begin
            state     <= bus_pkg::RX_FREE;
            mask_left <= '0;
            addr      <= '0;
            data      <= '0;
            return_id <= '0;
            dest      <= '0;
            rw        <= 1'b0;
            size      <= '0;
        end else begin
            case (state)
                bus_pkg::RX_FREE: begin
                    if (set_receiver) begin
                        state <= bus_pkg::RX_ARMED;
                    end
                end
                bus_pkg::RX_ARMED: begin
                    if (bus_valid && (int'(bus_dest) == LOC)) begin
                        addr      <= bus[bus_pkg::ADDR_LSB +: bus_pkg::ADDR_W];
                        return_id <= bus[bus_pkg::RET_LSB +: bus_pkg::LOC_W];
                        dest      <= bus_dest;
                        rw        <= bus[bus_pkg::RW_BIT];
                        // the mask is kept in the top bits of size.
                        size      <= {bus_mask, {(bus_pkg::SIZE_W - bus_pkg::MASK_W){1'b0}}};
                        mask_left <= bus_mask;
                        state     <= (bus_mask == '0) ? bus_pkg::RX_FULL : bus_pkg::RX_CAPTURE;
                    end
                end
                bus_pkg::RX_CAPTURE: begin
                    if (bus_valid) begin
                        // slots outside the mask keep what they held before.
                        data[slot * bus_pkg::WORD_W +: bus_pkg::WORD_W] <=
                            bus[bus_pkg::DATA_LSB +: bus_pkg::WORD_W];
                        mask_left <= bus_pkg::clear_low(mask_left);
                        if (bus_pkg::clear_low(mask_left) == '0) begin
                            state <= bus_pkg::RX_FULL;
                        end
                    end
                end
                default: begin
                    if (read) begin
                        state <= bus_pkg::RX_FREE;
                    end
                end
            endcase
        end
    end

    // the arbiter must not arm a receiver that is still busy or unread.
    a_set_when_free: assert property (
        @(posedge clk_bus) disable iff (!arst_n) set_receiver |-> state == bus_pkg::RX_FREE
    );

endmodule

// File: logic/bus_fabric_top.sv
`timescale 1ns/1ps

module bus_fabric_top #(
    parameter int NUM_TX = 2,
    parameter int NUM_RX = 2
) (
    input  logic                        clk_bus,
    input  logic                        arst_n,

    // core side of sender 0.
    input  logic                        tx_req_0,
    input  logic [bus_pkg::ADDR_W-1:0]  tx_addr_0,
    input  logic [bus_pkg::LINE_W-1:0]  tx_data_0,
    input  logic [bus_pkg::MASK_W-1:0]  tx_mask_0,
    input  logic [bus_pkg::LOC_W-1:0]   tx_dest_0,
    input  logic [bus_pkg::LOC_W-1:0]   tx_return_id_0,
    input  logic                        tx_rw_0,
    output logic                        tx_ack_0,

    // core side of sender 1.
    input  logic                        tx_req_1,
    input  logic [bus_pkg::ADDR_W-1:0]  tx_addr_1,
    input  logic [bus_pkg::LINE_W-1:0]  tx_data_1,
    input  logic [bus_pkg::MASK_W-1:0]  tx_mask_1,
    input  logic [bus_pkg::LOC_W-1:0]   tx_dest_1,
    input  logic [bus_pkg::LOC_W-1:0]   tx_return_id_1,
    input  logic                        tx_rw_1,
    output logic                        tx_ack_1,

    // consumer side of receiver 0.
    input  logic                        rx_read_0,
    output logic                        rx_full_0,
    output logic [bus_pkg::ADDR_W-1:0]  rx_addr_0,
    output logic [bus_pkg::LINE_W-1:0]  rx_data_0,
    output logic [bus_pkg::LOC_W-1:0]   rx_return_id_0,
    output logic [bus_pkg::LOC_W-1:0]   rx_dest_0,
    output logic                        rx_rw_0,
    output logic [bus_pkg::SIZE_W-1:0]  rx_size_0,

    // consumer side of receiver 1.
    input  logic                        rx_read_1,
    output logic                        rx_full_1,
    output logic [bus_pkg::ADDR_W-1:0]  rx_addr_1,
    output logic [bus_pkg::LINE_W-1:0]  rx_data_1,
    output logic [bus_pkg::LOC_W-1:0]   rx_return_id_1,
    output logic [bus_pkg::LOC_W-1:0]   rx_dest_1,
    output logic                        rx_rw_1,
    output logic [bus_pkg::SIZE_W-1:0]  rx_size_1
);

    logic [NUM_TX-1:0]                     bus_req;
    logic [NUM_TX-1:0][bus_pkg::LOC_W-1:0] bus_dest;
    logic [NUM_TX-1:0][bus_pkg::BUS_W-1:0] bus_word;
    logic [NUM_TX-1:0]                     done;
    logic [NUM_TX-1:0]                     grant;
    logic [NUM_RX-1:0]                     set_receiver;
    logic [NUM_RX-1:0]                     free_bau;
    logic [bus_pkg::BUS_W-1:0]             bus;

    bus_sender i_sender_0 (
        .clk_bus(clk_bus), .arst_n(arst_n),
        .req(tx_req_0), .addr(tx_addr_0), .data(tx_data_0), .mask(tx_mask_0),
        .dest(tx_dest_0), .return_id(tx_return_id_0), .rw(tx_rw_0),
        .grant(grant[0]), .ack(tx_ack_0), .bus_req(bus_req[0]),
        .bus_dest(bus_dest[0]), .bus_word(bus_word[0]), .done(done[0])
    );

    bus_sender i_sender_1 (
        .clk_bus(clk_bus), .arst_n(arst_n),
        .req(tx_req_1), .addr(tx_addr_1), .data(tx_data_1), .mask(tx_mask_1),
        .dest(tx_dest_1), .return_id(tx_return_id_1), .rw(tx_rw_1),
        .grant(grant[1]), .ack(tx_ack_1), .bus_req(bus_req[1]),
        .bus_dest(bus_dest[1]), .bus_word(bus_word[1]), .done(done[1])
    );

    bus_arbiter #(.NUM_TX(NUM_TX), .NUM_RX(NUM_RX)) i_bau (
        .clk_bus(clk_bus), .arst_n(arst_n),
        .bus_req(bus_req), .bus_dest(bus_dest), .bus_word(bus_word), .done(done),
        .free_bau(free_bau), .grant(grant), .set_receiver(set_receiver), .bus(bus)
    );

    bus_receiver #(.LOC(0)) i_receiver_0 (
        .clk_bus(clk_bus), .arst_n(arst_n), .bus(bus),
        .set_receiver(set_receiver[0]), .read(rx_read_0),
        .full(rx_full_0), .free_bau(free_bau[0]), .addr(rx_addr_0), .data(rx_data_0),
        .return_id(rx_return_id_0), .dest(rx_dest_0), .rw(rx_rw_0), .size(rx_size_0)
    );

    bus_receiver #(.LOC(1)) i_receiver_1 (
        .clk_bus(clk_bus), .arst_n(arst_n), .bus(bus),
        .set_receiver(set_receiver[1]), .read(rx_read_1),
        .full(rx_full_1), .free_bau(free_bau[1]), .addr(rx_addr_1), .data(rx_data_1),
        .return_id(rx_return_id_1), .dest(rx_dest_1), .rw(rx_rw_1), .size(rx_size_1)
    );

endmodule

// File: verif/tb_bus_fabric.sv
`timescale 1ns/1ps

module tb_bus_fabric;

    localparam int PLANNED_XFERS  = 50;
    localparam int TIMEOUT_CYCLES = 40 * PLANNED_XFERS + 200;

    // one transfer as the core sees it, plus the consumer's read delay.
    typedef struct packed {
        logic [bus_pkg::ADDR_W-1:0] addr;
        logic [bus_pkg::LINE_W-1:0] data;
        logic [bus_pkg::MASK_W-1:0] mask;
        logic [bus_pkg::LOC_W-1:0]  dest;
        logic [bus_pkg::LOC_W-1:0]  return_id;
        logic                       rw;
        logic [2:0]                 read_delay;
    } xfer_t;

    typedef struct packed {
        logic [bus_pkg::ADDR_W-1:0] addr;
        logic [bus_pkg::LINE_W-1:0] data;
        logic [bus_pkg::LOC_W-1:0]  return_id;
        logic [bus_pkg::LOC_W-1:0]  dest;
        logic                       rw;
        logic [bus_pkg::SIZE_W-1:0] size;
    } rx_view_t;

    logic                       clk_bus;
    logic                       arst_n;
    logic                       tx_req_0;
    logic [bus_pkg::ADDR_W-1:0] tx_addr_0;
    logic [bus_pkg::LINE_W-1:0] tx_data_0;
    logic [bus_pkg::MASK_W-1:0] tx_mask_0;
    logic [bus_pkg::LOC_W-1:0]  tx_dest_0;
    logic [bus_pkg::LOC_W-1:0]  tx_return_id_0;
    logic                       tx_rw_0;
    logic                       tx_ack_0;
    logic                       tx_req_1;
    logic [bus_pkg::ADDR_W-1:0] tx_addr_1;
    logic [bus_pkg::LINE_W-1:0] tx_data_1;
    logic [bus_pkg::MASK_W-1:0] tx_mask_1;
    logic [bus_pkg::LOC_W-1:0]  tx_dest_1;
    logic [bus_pkg::LOC_W-1:0]  tx_return_id_1;
    logic                       tx_rw_1;
    logic                       tx_ack_1;
    logic                       rx_read_0;
    logic                       rx_full_0;
    logic [bus_pkg::ADDR_W-1:0] rx_addr_0;
    logic [bus_pkg::LINE_W-1:0] rx_data_0;
    logic [bus_pkg::LOC_W-1:0]  rx_return_id_0;
    logic [bus_pkg::LOC_W-1:0]  rx_dest_0;
    logic                       rx_rw_0;
    logic [bus_pkg::SIZE_W-1:0] rx_size_0;
    logic                       rx_read_1;
    logic                       rx_full_1;
    logic [bus_pkg::ADDR_W-1:0] rx_addr_1;
    logic [bus_pkg::LINE_W-1:0] rx_data_1;
    logic [bus_pkg::LOC_W-1:0]  rx_return_id_1;
    logic [bus_pkg::LOC_W-1:0]  rx_dest_1;
    logic                       rx_rw_1;
    logic [bus_pkg::SIZE_W-1:0] rx_size_1;

    integer seed = 32'hcf21_141e;
    int     cycles = 0;
    int     data_errors = 0;
    int     seq_errors = 0;
    bit     hold_reads = 1'b0;
    int     checked [2] = '{0, 0};
    int     countdown [2] = '{0, 0};
    bit     full_seen [2] = '{1'b0, 1'b0};

    logic [bus_pkg::LINE_W-1:0] model [2] = '{'0, '0};
    xfer_t pending_0 [$];
    xfer_t pending_1 [$];

    bus_fabric_top i_dut (.*);

    initial begin : clock_gen
        clk_bus = 1'b0;
        forever begin
            #2 clk_bus = ~clk_bus;
        end
    end

    // ########################################
    // reference model
    // ########################################
    // masked words replace the old line and the rest of the line is kept.
    function automatic rx_view_t expect_capture(input xfer_t t,
                                                input logic [bus_pkg::LINE_W-1:0] prev);
        rx_view_t v;
        logic [bus_pkg::LINE_W-1:0] word_sel;
        word_sel = {{bus_pkg::WORD_W{t.mask[3]}}, {bus_pkg::WORD_W{t.mask[2]}},
                    {bus_pkg::WORD_W{t.mask[1]}}, {bus_pkg::WORD_W{t.mask[0]}}};
        v.addr      = t.addr;
        v.data      = (prev & ~word_sel) | (t.data & word_sel);
        v.return_id = t.return_id;
        v.dest      = t.dest;
        v.rw        = t.rw;
        v.size      = {t.mask, {(bus_pkg::SIZE_W - bus_pkg::MASK_W){1'b0}}};
        return v;
    endfunction

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    function automatic xfer_t make_xfer(input logic [3:0] dest, input logic [3:0] mask);
        xfer_t t;
        logic [31:0] r;
        r            = next_random();
        t.addr       = r[14:0];
        t.return_id  = r[18:15];
        t.rw         = r[19];
        t.read_delay = r[22:20];
        t.data       = {next_random(), next_random(), next_random(), next_random()};
        t.mask       = mask;
        t.dest       = dest;
        return t;
    endfunction

    function automatic rx_view_t view_of(input bit rx);
        if (rx) begin
            return {rx_addr_1, rx_data_1, rx_return_id_1, rx_dest_1, rx_rw_1, rx_size_1};
        end
        return {rx_addr_0, rx_data_0, rx_return_id_0, rx_dest_0, rx_rw_0, rx_size_0};
    endfunction

    // ########################################
    // core-side driving
    // ########################################
    task automatic start_send(input bit s, input xfer_t t);
        if (t.dest == 4'd0) begin
            pending_0.push_back(t);
        end else begin
            pending_1.push_back(t);
        end
        if (s) begin
            tx_req_1       <= 1'b1;
            tx_addr_1      <= t.addr;
            tx_data_1      <= t.data;
            tx_mask_1      <= t.mask;
            tx_dest_1      <= t.dest;
            tx_return_id_1 <= t.return_id;
            tx_rw_1        <= t.rw;
        end else begin
            tx_req_0       <= 1'b1;
            tx_addr_0      <= t.addr;
            tx_data_0      <= t.data;
            tx_mask_0      <= t.mask;
            tx_dest_0      <= t.dest;
            tx_return_id_0 <= t.return_id;
            tx_rw_0        <= t.rw;
        end
    endtask

    // the four-phase close waits for ack, drops req and waits for ack to drop.
    task automatic finish_send(input bit s);
        do @(posedge clk_bus);
        while (!(s ? tx_ack_1 : tx_ack_0));
        if (s) begin
            tx_req_1 <= 1'b0;
        end else begin
            tx_req_0 <= 1'b0;
        end
        do @(posedge clk_bus);
        while (s ? tx_ack_1 : tx_ack_0);
    endtask

    task automatic drain();
        do @(posedge clk_bus);
        while (checked[0] != pending_0.size() || checked[1] != pending_1.size() ||
               rx_full_0 || rx_full_1);
    endtask

    task automatic send_and_wait(input bit s, input xfer_t t);
        start_send(s, t);
        finish_send(s);
        drain();
    endtask

    // ########################################
    // comparator and consumer
    // ########################################
    task automatic report_mismatch(input bit rx, input string name,
                                   input logic [127:0] e, input logic [127:0] g);
        $display("Fail %0t: rx_%s_%0d expected %0h got %0h", $time, name, rx, e, g);
    endtask

    task automatic check_capture(input bit rx);
        xfer_t    t;
        rx_view_t exp;
        rx_view_t got;
        got = view_of(rx);
        if (checked[rx] >= (rx ? pending_1.size() : pending_0.size())) begin
            $display("receiver %0d became full at %0t with no transfer outstanding", rx, $time);
            data_errors++;
            countdown[rx] = 0;
        end else begin
            t   = rx ? pending_1[checked[1]] : pending_0[checked[0]];
            exp = expect_capture(t, model[rx]);
            model[rx] = exp.data;
            checked[rx]++;
            countdown[rx] = int'(t.read_delay);
            if (got.addr !== exp.addr) begin
                report_mismatch(rx, "addr", 128'(exp.addr), 128'(got.addr));
                data_errors++;
            end
            if (got.data !== exp.data) begin
                report_mismatch(rx, "data", exp.data, got.data);
                data_errors++;
            end
            if (got.return_id !== exp.return_id) begin
                report_mismatch(rx, "return_id", 128'(exp.return_id), 128'(got.return_id));
                data_errors++;
            end
            if (got.dest !== exp.dest) begin
                report_mismatch(rx, "dest", 128'(exp.dest), 128'(got.dest));
                data_errors++;
            end
            if (got.rw !== exp.rw) begin
                report_mismatch(rx, "rw", 128'(exp.rw), 128'(got.rw));
                data_errors++;
            end
            if (got.size !== exp.size) begin
                report_mismatch(rx, "size", 128'(exp.size), 128'(got.size));
                data_errors++;
            end
        end
    endtask

    // checks each new capture, then reads it after its delay.
    task automatic service_receiver(input bit rx);
        logic full_now;
        logic read_now;
        full_now = rx ? rx_full_1 : rx_full_0;
        read_now = rx ? rx_read_1 : rx_read_0;
        if (read_now) begin
            if (rx) rx_read_1 <= 1'b0;
            else rx_read_0 <= 1'b0;
        end else if (full_now && !full_seen[rx]) begin
            check_capture(rx);
        end else if (full_now && !hold_reads) begin
            if (countdown[rx] == 0) begin
                if (rx) rx_read_1 <= 1'b1;
                else rx_read_0 <= 1'b1;
            end else begin
                countdown[rx]--;
            end
        end
        full_seen[rx] = full_now;
    endtask

    initial begin : compare_proc
        rx_read_0 = 1'b0;
        rx_read_1 = 1'b0;
        forever begin
            @(posedge clk_bus);
            service_receiver(1'b0);
            service_receiver(1'b1);
        end
    end

    initial begin : watchdog
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_bus);
            cycles++;
        end
        $display("timeout after %0d cycles, a transfer or handshake never completed", cycles);
        $display("closing: %0d captures checked, %0d data errors, %0d sequence errors",
                 checked[0] + checked[1], data_errors, seq_errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ########################################
    // test sequence
    // ########################################
    initial begin : main_flow
        xfer_t       t;
        xfer_t       u;
        rx_view_t    held;
        logic [31:0] r;
        int          base;
        arst_n         = 1'b0;
        tx_req_0       = 1'b0;
        tx_addr_0      = '0;
        tx_data_0      = '0;
        tx_mask_0      = '0;
        tx_dest_0      = '0;
        tx_return_id_0 = '0;
        tx_rw_0        = 1'b0;
        tx_req_1       = 1'b0;
        tx_addr_1      = '0;
        tx_data_1      = '0;
        tx_mask_1      = '0;
        tx_dest_1      = '0;
        tx_return_id_1 = '0;
        tx_rw_1        = 1'b0;
        repeat (5) @(posedge clk_bus);
        arst_n <= 1'b1;
        @(posedge clk_bus);

        if (rx_full_0 || rx_full_1 || tx_ack_0 || tx_ack_1) begin
            $display("full or ack not idle after reset at %0t", $time);
            seq_errors++;
        end
        if (view_of(1'b0) !== '0 || view_of(1'b1) !== '0) begin
            $display("receiver outputs not cleared by reset at %0t", $time);
            seq_errors++;
        end
        send_and_wait(1'b0, make_xfer(4'd0, 4'b1111));

        // partial masks on top of the line left by the previous transfer.
        send_and_wait(1'b0, make_xfer(4'd0, 4'b0110));
        send_and_wait(1'b1, make_xfer(4'd0, 4'b1001));
        send_and_wait(1'b0, make_xfer(4'd0, 4'b0100));

        // transfers to receiver 1 leave the outputs of receiver 0 untouched.
        held = view_of(1'b0);
        send_and_wait(1'b0, make_xfer(4'd1, 4'b1011));
        send_and_wait(1'b1, make_xfer(4'd1, 4'b0011));
        if (view_of(1'b0) !== held) begin
            $display("receiver 0 took a transfer addressed to receiver 1 at %0t", $time);
            seq_errors++;
        end

        // second transfer must wait behind the unread first one.
        hold_reads = 1'b1;
        start_send(1'b0, make_xfer(4'd0, 4'b1111));
        finish_send(1'b0);
        base = checked[0];
        start_send(1'b1, make_xfer(4'd0, 4'b0101));
        repeat (20) begin
            @(posedge clk_bus);
            if (tx_ack_1) begin
                $display("sender 1 acknowledged at %0t while receiver 0 was unread", $time);
                seq_errors++;
            end
            if (checked[0] != base || !rx_full_0) begin
                $display("receiver 0 lost its unread transfer at %0t", $time);
                seq_errors++;
            end
        end
        hold_reads = 1'b0;
        finish_send(1'b1);
        drain();

        t = make_xfer(4'd0, 4'b1101);
        u = make_xfer(4'd1, 4'b0111);
        start_send(1'b0, t);
        start_send(1'b1, u);
        finish_send(1'b0);
        finish_send(1'b1);
        drain();

        repeat (40) begin
            r = next_random();
            start_send(r[5], make_xfer({3'b000, r[0]}, r[4:1]));
            finish_send(r[5]);
        end
        drain();

        $display("closing: %0d captures checked, %0d data errors, %0d sequence errors",
                 checked[0] + checked[1], data_errors, seq_errors);
        if (data_errors == 0 && seq_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: bus_fabric_top.f
logic/bus_pkg.sv
logic/bus_sender.sv
logic/bus_arbiter.sv
logic/bus_receiver.sv
logic/bus_fabric_top.sv
verif/tb_bus_fabric.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -j 0 \
    --top-module tb_bus_fabric -f bus_fabric_top.f -o tb_bus_fabric \
    && ./obj_dir/tb_bus_fabric > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat "$LOG"
grep -qF "*** TEST FAILED ***" "$LOG" && { echo "simulation reported failure"; exit 1; }
echo "simulation finished without failure"
exit 0
